//--- design/core_pkg.sv
`default_nettype none

package core_pkg;

    // major opcodes
    localparam logic [6:0] OP_REG    = 7'h33;
    localparam logic [6:0] OP_IMM    = 7'h13;
    localparam logic [6:0] OP_BRANCH = 7'h63;
    localparam logic [6:0] OP_JAL    = 7'h6f;
    localparam logic [6:0] OP_JALR   = 7'h67;
    localparam logic [6:0] OP_LUI    = 7'h37;
    localparam logic [6:0] OP_AUIPC  = 7'h17;
    localparam logic [6:0] OP_SYSTEM = 7'h73;

    localparam logic [31:0] INST_EBREAK = 32'h0010_0073;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE,
        BR_LTU,
        BR_GEU
    } branch_e;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
    } fetch_t;

    typedef struct packed {
        alu_op_e alu_op;
        branch_e branch;
        logic    src1_is_pc;
        logic    src2_is_imm;
        logic    is_jal;
        logic    is_jalr;
        logic    gpr_we;
        logic    halt;
        logic    illegal;
    } decode_ctrl_t;

    typedef struct packed {
        logic [31:0]  pc;
        decode_ctrl_t ctrl;
        logic [3:0]   rd;
        logic [31:0]  src1;
        logic [31:0]  src2;
        logic [31:0]  imm;
    } issue_t;

    typedef struct packed {
        logic        we;
        logic [3:0]  rd;
        logic [31:0] data;
    } wb_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [3:0]  rd;
        logic        we;
        logic [31:0] wdata;
        logic [31:0] next_pc;
        logic        halt;
        logic        illegal;
    } retire_t;

endpackage

`default_nettype wire

//--- design/inst_decoder.sv
`default_nettype none

module inst_decoder import core_pkg::*; (
    input  wire logic [31:0] inst,
    output decode_ctrl_t     ctrl,
    output logic [31:0]      imm
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       legal;
    logic       uses_rd;
    logic       uses_rs1;
    logic       uses_rs2;
    logic       bad_reg;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    always_comb begin
        ctrl     = '0;
        imm      = '0;
        legal    = 1'b0;
        uses_rd  = 1'b0;
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        case (opcode)
            OP_REG: begin
                legal       = 1'b1;
                uses_rd     = 1'b1;
                uses_rs1    = 1'b1;
                uses_rs2    = 1'b1;
                ctrl.gpr_we = 1'b1;
                case ({funct7, funct3})
                    {7'h00, 3'h0}: ctrl.alu_op = ALU_ADD;
                    {7'h20, 3'h0}: ctrl.alu_op = ALU_SUB;
                    {7'h00, 3'h1}: ctrl.alu_op = ALU_SLL;
                    {7'h00, 3'h2}: ctrl.alu_op = ALU_SLT;
                    {7'h00, 3'h3}: ctrl.alu_op = ALU_SLTU;
                    {7'h00, 3'h4}: ctrl.alu_op = ALU_XOR;
                    {7'h00, 3'h5}: ctrl.alu_op = ALU_SRL;
                    {7'h20, 3'h5}: ctrl.alu_op = ALU_SRA;
                    {7'h00, 3'h6}: ctrl.alu_op = ALU_OR;
                    {7'h00, 3'h7}: ctrl.alu_op = ALU_AND;
                    default:       legal = 1'b0;
                endcase
            end
            OP_IMM: begin
                legal            = 1'b1;
                uses_rd          = 1'b1;
                uses_rs1         = 1'b1;
                ctrl.gpr_we      = 1'b1;
                ctrl.src2_is_imm = 1'b1;
                imm              = {{20{inst[31]}}, inst[31:20]};
                case (funct3)
                    3'h0: ctrl.alu_op = ALU_ADD;
                    3'h2: ctrl.alu_op = ALU_SLT;
                    3'h3: ctrl.alu_op = ALU_SLTU;
                    3'h4: ctrl.alu_op = ALU_XOR;
                    3'h6: ctrl.alu_op = ALU_OR;
                    3'h7: ctrl.alu_op = ALU_AND;
                    3'h1: begin
                        ctrl.alu_op = ALU_SLL;
                        legal       = (funct7 == 7'h00);
                    end
                    default: begin
                        // shift right, funct7 picks logical or arithmetic
                        ctrl.alu_op = (funct7 == 7'h20) ? ALU_SRA : ALU_SRL;
                        legal       = (funct7 == 7'h00) | (funct7 == 7'h20);
                    end
                endcase
            end
            OP_LUI, OP_AUIPC: begin
                legal            = 1'b1;
                uses_rd          = 1'b1;
                ctrl.gpr_we      = 1'b1;
                ctrl.src2_is_imm = 1'b1;
                ctrl.src1_is_pc  = (opcode == OP_AUIPC);
                ctrl.alu_op      = (opcode == OP_LUI) ? ALU_PASS_B : ALU_ADD;
                imm              = {inst[31:12], 12'b0};
            end
            OP_JAL: begin
                legal       = 1'b1;
                uses_rd     = 1'b1;
                ctrl.gpr_we = 1'b1;
                ctrl.is_jal = 1'b1;
                imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            OP_JALR: begin
                legal        = (funct3 == 3'h0);
                uses_rd      = 1'b1;
                uses_rs1     = 1'b1;
                ctrl.gpr_we  = 1'b1;
                ctrl.is_jalr = 1'b1;
                imm          = {{20{inst[31]}}, inst[31:20]};
            end
            OP_BRANCH: begin
                legal    = 1'b1;
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
                case (funct3)
                    3'h0:    ctrl.branch = BR_EQ;
                    3'h1:    ctrl.branch = BR_NE;
                    3'h4:    ctrl.branch = BR_LT;
                    3'h5:    ctrl.branch = BR_GE;
                    3'h6:    ctrl.branch = BR_LTU;
                    3'h7:    ctrl.branch = BR_GEU;
                    default: legal = 1'b0;
                endcase
            end
            OP_SYSTEM: begin
                // only ebreak, everything else in SYSTEM is unsupported
                legal     = (inst == INST_EBREAK);
                ctrl.halt = 1'b1;
            end
            default: legal = 1'b0;
        endcase

        // RV32E has x0..x15 only
        bad_reg = (uses_rd & inst[11]) | (uses_rs1 & inst[19]) | (uses_rs2 & inst[24]);

        if (!legal || bad_reg) begin
            ctrl         = '0;
            ctrl.illegal = 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- design/reg_file.sv
`default_nettype none

module reg_file import core_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic [3:0]  rs1,
    input  wire logic [3:0]  rs2,
    output logic [31:0]      rdata1,
    output logic [31:0]      rdata2,
    input  wire wb_t         wb
);

    logic [31:0] regs [16];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.we && wb.rd != 4'd0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // x0 reads as zero
    assign rdata1 = (rs1 == 4'd0) ? 32'd0 : regs[rs1];
    assign rdata2 = (rs2 == 4'd0) ? 32'd0 : regs[rs2];

endmodule

`default_nettype wire

//--- design/decode_stage.sv
`default_nettype none

module decode_stage import core_pkg::*; (
    input  wire logic         clk,
    input  wire logic         rst,
    input  wire logic         fetch_valid,
    input  wire fetch_t       fetch,
    output logic              fetch_ready,
    input  wire decode_ctrl_t ctrl,
    input  wire logic [31:0]  imm,
    input  wire logic [31:0]  rdata1,
    input  wire logic [31:0]  rdata2,
    input  wire wb_t          wb,
    input  wire logic         redirect_valid,
    output logic              issue_valid,
    output issue_t            issue,
    input  wire logic         issue_ready
);

    logic [3:0]  rs1;
    logic [3:0]  rs2;
    logic [31:0] src1;
    logic [31:0] src2;
    logic        accept;

    assign rs1 = fetch.inst[18:15];
    assign rs2 = fetch.inst[23:20];

    // stage moves only when execute can take the current entry
    assign fetch_ready = issue_ready;
    assign accept      = fetch_valid & issue_ready;

    // write from the instruction ahead lands on this same edge
    assign src1 = (wb.we && wb.rd == rs1) ? wb.data : rdata1;
    assign src2 = (wb.we && wb.rd == rs2) ? wb.data : rdata2;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            issue_valid <= 1'b0;
        end else if (issue_ready) begin
            // wrong-path item is dropped when execute redirects
            issue_valid <= fetch_valid & ~redirect_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            issue.pc   <= fetch.pc;
            issue.ctrl <= ctrl;
            issue.rd   <= fetch.inst[10:7];
            issue.src1 <= src1;
            issue.src2 <= src2;
            issue.imm  <= imm;
        end
    end

endmodule

`default_nettype wire

//--- design/exec_stage.sv
`default_nettype none

module exec_stage import core_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        issue_valid,
    input  wire issue_t      issue,
    output logic             issue_ready,
    output wb_t              wb,
    output logic             redirect_valid,
    output logic [31:0]      redirect_pc,
    output logic             retire_valid,
    output retire_t          retire,
    input  wire logic        retire_ready
);

    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] alu_result;
    logic [31:0] link_pc;
    logic [31:0] next_pc;
    logic [31:0] wdata;
    logic        taken;
    logic        we;
    logic        fire;

    assign issue_ready = ~retire_valid | retire_ready;
    assign fire        = issue_valid & issue_ready;

    assign op_a = issue.ctrl.src1_is_pc ? issue.pc : issue.src1;
    assign op_b = issue.ctrl.src2_is_imm ? issue.imm : issue.src2;

    always_comb begin
        case (issue.ctrl.alu_op)
            ALU_SUB:    alu_result = op_a - op_b;
            ALU_SLT:    alu_result = {31'd0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu_result = {31'd0, op_a < op_b};
            ALU_AND:    alu_result = op_a & op_b;
            ALU_OR:     alu_result = op_a | op_b;
            ALU_XOR:    alu_result = op_a ^ op_b;
            ALU_SLL:    alu_result = op_a << op_b[4:0];
            ALU_SRL:    alu_result = op_a >> op_b[4:0];
            ALU_SRA:    alu_result = $unsigned($signed(op_a) >>> op_b[4:0]);
            ALU_PASS_B: alu_result = op_b;
            default:    alu_result = op_a + op_b;
        endcase
    end

    // branch compare works on the register operands
    always_comb begin
        case (issue.ctrl.branch)
            BR_EQ:   taken = (issue.src1 == issue.src2);
            BR_NE:   taken = (issue.src1 != issue.src2);
            BR_LT:   taken = ($signed(issue.src1) < $signed(issue.src2));
            BR_GE:   taken = ($signed(issue.src1) >= $signed(issue.src2));
            BR_LTU:  taken = (issue.src1 < issue.src2);
            BR_GEU:  taken = (issue.src1 >= issue.src2);
            default: taken = 1'b0;
        endcase
    end

    assign link_pc = issue.pc + 32'd4;

    always_comb begin
        if (taken || issue.ctrl.is_jal) begin
            next_pc = issue.pc + issue.imm;
        end else if (issue.ctrl.is_jalr) begin
            next_pc = (issue.src1 + issue.imm) & ~32'd1;
        end else begin
            next_pc = link_pc;
        end
    end

    assign wdata = (issue.ctrl.is_jal || issue.ctrl.is_jalr) ? link_pc : alu_result;
    assign we    = issue.ctrl.gpr_we & (issue.rd != 4'd0);

    assign wb.we   = fire & we;
    assign wb.rd   = issue.rd;
    assign wb.data = wdata;

    assign redirect_valid = fire & (taken | issue.ctrl.is_jal | issue.ctrl.is_jalr);
    assign redirect_pc    = next_pc;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            retire_valid <= 1'b0;
        end else if (issue_ready) begin
            retire_valid <= issue_valid;
        end
    end

    // record holds while the consumer stalls
    always_ff @(posedge clk) begin
        if (fire) begin
            retire.pc      <= issue.pc;
            retire.rd      <= issue.rd;
            retire.we      <= we;
            retire.wdata   <= wdata;
            retire.next_pc <= next_pc;
            retire.halt    <= issue.ctrl.halt;
            retire.illegal <= issue.ctrl.illegal;
        end
    end

endmodule

`default_nettype wire

//--- design/core_slice_top.sv
`default_nettype none

module core_slice_top import core_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        fetch_valid,
    input  wire fetch_t      fetch,
    output logic             fetch_ready,
    output logic             redirect_valid,
    output logic [31:0]      redirect_pc,
    output logic             retire_valid,
    output retire_t          retire,
    input  wire logic        retire_ready
);

    decode_ctrl_t ctrl;
    logic [31:0]  imm;
    logic [31:0]  rdata1;
    logic [31:0]  rdata2;
    wb_t          wb;
    logic         issue_valid;
    issue_t       issue;
    logic         issue_ready;

    // decoder and register reads work on the incoming fetch word
    inst_decoder u_decoder (
        .inst (fetch.inst),
        .ctrl (ctrl),
        .imm  (imm)
    );

    reg_file u_reg_file (
        .clk    (clk),
        .rst    (rst),
        .rs1    (fetch.inst[18:15]),
        .rs2    (fetch.inst[23:20]),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .wb     (wb)
    );

    decode_stage u_decode (
        .clk            (clk),
        .rst            (rst),
        .fetch_valid    (fetch_valid),
        .fetch          (fetch),
        .fetch_ready    (fetch_ready),
        .ctrl           (ctrl),
        .imm            (imm),
        .rdata1         (rdata1),
        .rdata2         (rdata2),
        .wb             (wb),
        .redirect_valid (redirect_valid),
        .issue_valid    (issue_valid),
        .issue          (issue),
        .issue_ready    (issue_ready)
    );

    exec_stage u_exec (
        .clk            (clk),
        .rst            (rst),
        .issue_valid    (issue_valid),
        .issue          (issue),
        .issue_ready    (issue_ready),
        .wb             (wb),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .retire_valid   (retire_valid),
        .retire         (retire),
        .retire_ready   (retire_ready)
    );

endmodule

`default_nettype wire

//--- verification/tb_core_slice.sv
`default_nettype none

module tb_core_slice import core_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int STIM_WORDS   = 512;
    localparam int IMEM_WORDS   = 64;
    localparam int DRAIN_CYCLES = 8;

    logic        clk;
    logic        rst;
    logic        fetch_valid;
    fetch_t      fetch;
    logic        fetch_ready;
    logic        redirect_valid;
    logic [31:0] redirect_pc;
    logic        retire_valid;
    retire_t     retire;
    logic        retire_ready;

    logic [31:0] stim [STIM_WORDS];
    logic [31:0] imem [IMEM_WORDS];
    logic        imem_loaded [IMEM_WORDS];
    retire_t     expected_q [$];

    int      errors;
    int      retired;
    int      cycle;
    int      drain;
    int      timeout_cycles;
    logic    running;
    logic    halted;
    logic    held_valid;
    retire_t held;

    core_slice_top dut0 (
        .clk            (clk),
        .rst            (rst),
        .fetch_valid    (fetch_valid),
        .fetch          (fetch),
        .fetch_ready    (fetch_ready),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .retire_valid   (retire_valid),
        .retire         (retire),
        .retire_ready   (retire_ready)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic image_has(input logic [31:0] pc);
        return (pc[31:8] == 24'd0) && (pc[1:0] == 2'd0) && imem_loaded[pc[7:2]];
    endfunction

    task automatic check_value(input string what, input logic [127:0] actual,
                               input logic [127:0] expected);
        if (actual !== expected) begin
            errors++;
            $display("** Error at %0t ns: %s is %0h, expected %0h",
                     $time, what, actual, expected);
        end
    endtask

    // records are 8 words wide, first word is the kind
    task automatic load_stimulus();
        int      i;
        logic    done_loading;
        retire_t rec;
        for (int k = 0; k < IMEM_WORDS; k++) begin
            imem_loaded[k] = 1'b0;
        end
        $readmemh("verification/core_slice_stimulus.txt", stim);
        i = 0;
        done_loading = 1'b0;
        while (!done_loading) begin
            if (i + 8 > STIM_WORDS) begin
                $display("stimulus file has no end record");
                errors++;
                done_loading = 1'b1;
            end else if (stim[i] == 32'd0) begin
                if (stim[i+1][31:8] != 24'd0) begin
                    $display("program address %0h is outside the instruction memory",
                             stim[i+1]);
                    errors++;
                end else begin
                    imem[stim[i+1][7:2]]        = stim[i+2];
                    imem_loaded[stim[i+1][7:2]] = 1'b1;
                end
            end else if (stim[i] == 32'd1) begin
                rec.pc      = stim[i+1];
                rec.rd      = stim[i+2][3:0];
                rec.we      = stim[i+3][0];
                rec.wdata   = stim[i+4];
                rec.next_pc = stim[i+5];
                rec.halt    = stim[i+6][0];
                rec.illegal = stim[i+7][0];
                expected_q.push_back(rec);
            end else if (stim[i] == 32'd2) begin
                done_loading = 1'b1;
            end else begin
                $display("stimulus file has an unknown record kind %0h", stim[i]);
                errors++;
                done_loading = 1'b1;
            end
            i += 8;
        end
    endtask

    task automatic compare_record(input retire_t got);
        retire_t want;
        if (halted) begin
            $display("record at pc %0h retired after the halt record", got.pc);
            errors++;
        end else if (expected_q.size() == 0) begin
            $display("record at pc %0h retired but the trace has no record left", got.pc);
            errors++;
        end else begin
            want = expected_q.pop_front();
            check_value("retire pc", 128'(got.pc), 128'(want.pc));
            check_value("retire we", 128'(got.we), 128'(want.we));
            check_value("retire next_pc", 128'(got.next_pc), 128'(want.next_pc));
            check_value("retire halt", 128'(got.halt), 128'(want.halt));
            check_value("retire illegal", 128'(got.illegal), 128'(want.illegal));
            // rd and wdata only matter for a register write
            if (want.we) begin
                check_value("retire rd", 128'(got.rd), 128'(want.rd));
                check_value("retire wdata", 128'(got.wdata), 128'(want.wdata));
            end
            retired++;
            halted = got.halt;
        end
    endtask

    // samples pre-edge values of the retire port
    task automatic monitor_cycle();
        if (held_valid) begin
            if (!retire_valid) begin
                $display("retire_valid dropped at %0t ns before the record was taken", $time);
                errors++;
            end
            check_value("stalled retire record", 128'(retire), 128'(held));
        end
        if (retire_valid && retire_ready) begin
            compare_record(retire);
        end
        held_valid = retire_valid && !retire_ready;
        held       = retire;
    endtask

    // fetch source, follows redirects
    initial begin : fetch_model
        logic [31:0] pc_next;
        fetch_valid <= 1'b0;
        fetch       <= '0;
        forever begin
            @(posedge clk);
            if (rst) begin
                fetch_valid <= 1'b0;
                fetch.pc    <= 32'd0;
                fetch.inst  <= 32'd0;
            end else begin
                pc_next = fetch.pc;
                if (redirect_valid) begin
                    pc_next = redirect_pc;
                end else if (fetch_valid && fetch_ready) begin
                    pc_next = fetch.pc + 32'd4;
                end
                fetch.pc    <= pc_next;
                fetch.inst  <= image_has(pc_next) ? imem[pc_next[7:2]] : 32'd0;
                fetch_valid <= image_has(pc_next);
            end
        end
    end

    initial begin : ready_model
        int seed;
        int rnd;
        seed = 4;
        retire_ready <= 1'b0;
        forever begin
            @(posedge clk);
            rnd = $random(seed);
            retire_ready <= rst ? 1'b0 : rnd[0];
        end
    end

    initial begin
        rst <= 1'b1;
        errors     = 0;
        retired    = 0;
        cycle      = 0;
        drain      = 0;
        halted     = 1'b0;
        held_valid = 1'b0;
        held       = '0;
        load_stimulus();
        timeout_cycles = 8 * expected_q.size() + 100;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        running = 1'b1;
        while (running) begin
            @(posedge clk);
            cycle++;
            monitor_cycle();
            // keep watching a few cycles past the halt for stray records
            if (halted) begin
                drain++;
            end
            if (drain == DRAIN_CYCLES) begin
                running = 1'b0;
            end else if (!halted && cycle >= timeout_cycles) begin
                $display("timeout after %0d cycles, the halt record never retired", cycle);
                errors++;
                running = 1'b0;
            end
        end

        if (expected_q.size() != 0) begin
            $display("%0d trace records never retired", expected_q.size());
            errors++;
        end
        $display("%0d records retired, %0d errors", retired, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
design/core_pkg.sv
design/inst_decoder.sv
design/reg_file.sv
design/decode_stage.sv
design/exec_stage.sv
design/core_slice_top.sv
verification/tb_core_slice.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the core slice testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --top-module tb_core_slice -f flist.f > build.log 2>&1
build_status=$?
cat build.log
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/Vtb_core_slice > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Test FAILED" sim.log; then
    exit 1
fi
exit 0

//--- verification/core_slice_stimulus.txt
// program word    0 addr inst 0 0 0 0 0
// retire record   1 pc rd we wdata next_pc halt illegal, a record of kind 2 ends the list
0 00000000 00500093 0 0 0 0 0  // addi x1, x0, 5
0 00000004 ffd08113 0 0 0 0 0  // addi x2, x1, -3
0 00000008 002081b3 0 0 0 0 0  // add x3, x1, x2
0 0000000c 40310233 0 0 0 0 0  // sub x4, x2, x3
0 00000010 123452b7 0 0 0 0 0  // lui x5, 0x12345
0 00000014 00001317 0 0 0 0 0  // auipc x6, 0x1
0 00000018 00908013 0 0 0 0 0  // addi x0, x1, 9
0 0000001c 001003b3 0 0 0 0 0  // add x7, x0, x1
0 00000020 0000a403 0 0 0 0 0  // lw x8, 0(x1)
0 00000024 00708663 0 0 0 0 0  // beq x1, x7, +12
0 00000028 00100493 0 0 0 0 0  // addi x9, x0, 1 on the wrong path
0 00000030 00709463 0 0 0 0 0  // bne x1, x7, +8 falls through
0 00000034 40125613 0 0 0 0 0  // srai x12, x4, 1
0 00000038 002626b3 0 0 0 0 0  // slt x13, x12, x2
0 0000003c 00c0056f 0 0 0 0 0  // jal x10, +12
0 00000040 00200493 0 0 0 0 0  // addi x9, x0, 2 on the wrong path
0 00000048 010505e7 0 0 0 0 0  // jalr x11, 16(x10)
0 0000004c 00300493 0 0 0 0 0  // addi x9, x0, 3 on the wrong path
0 00000050 0ff2c713 0 0 0 0 0  // xori x14, x5, 0xff
0 00000054 00100073 0 0 0 0 0  // ebreak
// retire trace in program order
1 00000000 1 1 00000005 00000004 0 0
1 00000004 2 1 00000002 00000008 0 0
1 00000008 3 1 00000007 0000000c 0 0
1 0000000c 4 1 fffffffb 00000010 0 0
1 00000010 5 1 12345000 00000014 0 0
1 00000014 6 1 00001014 00000018 0 0
1 00000018 0 0 0000000e 0000001c 0 0
1 0000001c 7 1 00000005 00000020 0 0
1 00000020 8 0 00000000 00000024 0 1
1 00000024 0 0 00000000 00000030 0 0
1 00000030 0 0 00000000 00000034 0 0
1 00000034 c 1 fffffffd 00000038 0 0
1 00000038 d 1 00000001 0000003c 0 0
1 0000003c a 1 00000040 00000048 0 0
1 00000048 b 1 0000004c 00000050 0 0
1 00000050 e 1 123450ff 00000054 0 0
1 00000054 0 0 00000000 00000058 1 0
2 00000000 0 0 00000000 00000000 0 0
